// File: spi_reg_slave.f
common/spi_pkg.sv
common/reg_pkg.sv
spi_slave/spi_pin_sync.sv
spi_slave/spi_shift_engine.sv
hw/spi_reg_bank.sv
hw/spi_reg_slave.sv
bench/spi_checker.sv
bench/tb_spi_reg_slave.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the SPI register slave testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --top-module tb_spi_reg_slave -f spi_reg_slave.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/Vtb_spi_reg_slave > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported errors, see $LOG"
    exit 1
fi

echo "Simulation finished without errors"
exit 0

// File: bench/tb_spi_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_reg_slave;
    import spi_pkg::*;
    import reg_pkg::*;

    localparam int TXN_COUNT = 200;
    localparam int HALF_CYCLES = 8; // clk_raw cycles per sclk half period.
    localparam int TIMEOUT_CYCLES = TXN_COUNT * 40 * HALF_CYCLES * 3 / 2;

    logic          clk_raw = 1'b0;
    logic          rst_n;
    spi_mode_t     mode;
    logic          sclk;
    logic          mosi;
    logic          csn;
    logic          miso;
    logic          miso_en;
    reg_wr_event_t wr_event;
    int            error_count;
    int            cycle_count = 0;
    integer        seed;

    always #20 clk_raw = ~clk_raw; // 40 ns period.

    spi_reg_slave i_spi_reg_slave (
        .clk_raw  (clk_raw),
        .rst_n    (rst_n),
        .mode     (mode),
        .sclk     (sclk),
        .mosi     (mosi),
        .csn      (csn),
        .miso     (miso),
        .miso_en  (miso_en),
        .wr_event (wr_event)
    );

    spi_checker i_spi_checker (
        .clk_raw     (clk_raw),
        .rst_n       (rst_n),
        .csn         (csn),
        .miso_en     (miso_en),
        .wr_event    (wr_event),
        .error_count (error_count)
    );

    task automatic wait_half_period();
        repeat (HALF_CYCLES) @(posedge clk_raw);
    endtask

    // One SPI transaction as master, miso captured on each sampling edge.
    task automatic run_txn(input spi_mode_t m, input logic rw, input logic [6:0] addr,
                           input int nbytes);
        logic [31:0] sent;
        logic [31:0] got;
        int          nbits;
        int          k;
        sent = {rw, addr, 24'h0};
        for (k = 1; k <= nbytes; k++) begin
            sent[31 - 8*k -: 8] = 8'($random(seed));
        end
        got = '0;
        nbits = FRAME_BITS * (nbytes + 1);
        mode <= m;
        sclk <= m.cpol; // Idle level.
        wait_half_period();
        csn <= 1'b0;
        if (!m.cpha) begin
            mosi <= sent[31]; // MSB goes out before the first edge.
        end
        wait_half_period();
        for (k = 0; k < nbits; k++) begin
            sclk <= ~m.cpol; // Leading edge.
            if (m.cpha) begin
                mosi <= sent[31 - k];
            end else begin
                got[31 - k] = miso;
            end
            wait_half_period();
            sclk <= m.cpol; // Trailing edge.
            if (m.cpha) begin
                got[31 - k] = miso;
            end else if (k + 1 < nbits) begin
                mosi <= sent[30 - k];
            end
            wait_half_period();
        end
        csn <= 1'b1;
        wait_half_period();
        i_spi_checker.check_txn(rw, addr, nbytes, sent, got);
    endtask

    initial begin
        logic [31:0] r;
        int          t;
        seed = 32'h200c_870b;
        rst_n <= 1'b0;
        mode  <= '0;
        sclk  <= 1'b0;
        mosi  <= 1'b0;
        csn   <= 1'b1;
        repeat (8) @(posedge clk_raw);
        rst_n <= 1'b1;
        wait_half_period();
        for (t = 0; t < TXN_COUNT; t++) begin
            r = $random(seed);
            // Addresses 0 to 9, bursts of 1 to 3 bytes.
            run_txn(spi_mode_t'(r[1:0]), r[2], 7'(r[15:8] % 8'd10),
                    int'(r[23:16] % 8'd3) + 1);
        end
        repeat (4) @(posedge clk_raw);
        i_spi_checker.print_summary();
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    always @(posedge clk_raw) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            i_spi_checker.print_summary();
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bench/spi_checker.sv
`timescale 1ns/1ps
`default_nettype none

module spi_checker (
    input  logic                   clk_raw,
    input  logic                   rst_n,
    input  logic                   csn,
    input  logic                   miso_en,
    input  reg_pkg::reg_wr_event_t wr_event,
    output int                     error_count
);
    import reg_pkg::*;

    logic [7:0]    model_regs [REG_COUNT] = '{default: 8'h00};
    logic [7:0]    model_count = 8'h00; // Completed in-map writes.
    reg_wr_event_t ev_log [$];
    int            ev_rd = 0;           // Next logged event to compare.
    logic [5:0]    csn_hist;
    int            txn_count = 0;
    int            mismatch_count = 0;
    int            strobe_errors = 0;
    int            enable_errors = 0;

    assign error_count = mismatch_count + strobe_errors + enable_errors;

    // Every write strobe is logged and matched later.
    always @(posedge clk_raw) begin
        if (rst_n && wr_event.valid) begin
            ev_log.push_back(wr_event);
        end
    end

    // miso_en follows csn, a few cycles late.
    always @(posedge clk_raw) begin
        csn_hist <= {csn_hist[4:0], csn};
        if (rst_n) begin
            if (&csn_hist && miso_en) begin
                $display("Error: miso_en is high while csn has been idle");
                enable_errors <= enable_errors + 1;
            end
            if (~|csn_hist && !miso_en) begin
                $display("Error: miso_en is low during an open transaction");
                enable_errors <= enable_errors + 1;
            end
        end
    end

    // Byte 0 of sent/got is the command byte, in bits 31:24.
    task automatic check_txn(input logic rw, input logic [6:0] addr, input int nbytes,
                             input logic [31:0] sent, input logic [31:0] got);
        logic [7:0]    sent_byte;
        logic [7:0]    got_byte;
        logic [7:0]    exp_byte;
        logic [6:0]    a;
        reg_wr_event_t ev;
        int            i;
        got_byte = got[31:24];
        if (got_byte !== model_count) begin // Status byte.
            $display("Mismatch miso status: expected %02h, got %02h", model_count, got_byte);
            mismatch_count++;
        end
        for (i = 1; i <= nbytes; i++) begin
            a = addr + 7'(i - 1);
            sent_byte = sent[31 - 8*i -: 8];
            got_byte = got[31 - 8*i -: 8];
            if (rw) begin
                exp_byte = (a < 7'(REG_COUNT)) ? model_regs[a[REG_ADDR_BITS-1:0]] : 8'h00;
                if (got_byte !== exp_byte) begin
                    $display("Mismatch miso addr %02h: expected %02h, got %02h",
                             a, exp_byte, got_byte);
                    mismatch_count++;
                end
            end else begin
                if (ev_rd >= ev_log.size()) begin
                    $display("Error: no write event seen for address %02h", a);
                    strobe_errors++;
                end else begin
                    ev = ev_log[ev_rd];
                    ev_rd++;
                    if (ev.addr !== a) begin
                        $display("Mismatch wr_event.addr: expected %02h, got %02h", a, ev.addr);
                        mismatch_count++;
                    end
                    if (ev.data !== sent_byte) begin
                        $display("Mismatch wr_event.data: expected %02h, got %02h",
                                 sent_byte, ev.data);
                        mismatch_count++;
                    end
                end
                if (a < 7'(REG_COUNT)) begin // Out-of-map writes are dropped.
                    model_regs[a[REG_ADDR_BITS-1:0]] = sent_byte;
                    model_count = model_count + 8'd1;
                end
            end
        end
        while (ev_rd < ev_log.size()) begin
            $display("Error: unexpected write event at address %02h", ev_log[ev_rd].addr);
            strobe_errors++;
            ev_rd++;
        end
        txn_count++;
    endtask

    task automatic print_summary();
        $display("Summary: %0d transactions, %0d mismatches, %0d strobe errors, %0d enable errors",
                 txn_count, mismatch_count, strobe_errors, enable_errors);
    endtask

endmodule

`default_nettype wire

// File: hw/spi_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_slave (
    input  logic                   clk_raw,
    input  logic                   rst_n,
    input  spi_pkg::spi_mode_t     mode,
    input  logic                   sclk,
    input  logic                   mosi,
    input  logic                   csn,
    output logic                   miso,
    output logic                   miso_en,
    output reg_pkg::reg_wr_event_t wr_event
);
    import spi_pkg::*;

    spi_edges_t edges;
    spi_frame_u rx_byte;
    logic [7:0] tx_byte;
    logic       byte_done;

    // Pin side in the clk_raw domain.
    spi_pin_sync i_spi_pin_sync (
        .clk_raw (clk_raw),
        .rst_n   (rst_n),
        .mode    (mode),
        .sclk    (sclk),
        .mosi    (mosi),
        .csn     (csn),
        .edges   (edges)
    );

    spi_shift_engine i_spi_shift_engine (
        .clk_raw   (clk_raw),
        .rst_n     (rst_n),
        .edges     (edges),
        .tx_byte   (tx_byte),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .miso      (miso),
        .miso_en   (miso_en)
    );

    // Command decode and register storage.
    spi_reg_bank i_spi_reg_bank (
        .clk_raw   (clk_raw),
        .rst_n     (rst_n),
        .start     (edges.start),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .tx_byte   (tx_byte),
        .wr_event  (wr_event)
    );

endmodule

`default_nettype wire

// File: hw/spi_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank (
    input  logic                  clk_raw,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  byte_done,
    input  spi_pkg::spi_frame_u   rx_byte,
    output logic [7:0]            tx_byte,
    output reg_pkg::reg_wr_event_t wr_event
);
    import reg_pkg::*;

    logic [7:0] regs [REG_COUNT];
    logic [7:0] wr_count; // Completed in-map writes, mod 256.
    logic       cmd_next; // Next byte_done is the command byte.
    logic       rw_q;
    logic [6:0] addr_q;
    logic [7:0] tx_data;
    logic       wr_valid;
    logic [6:0] ev_addr;
    logic [7:0] ev_data;
    logic       addr_ok;

    // Out-of-map reads return zero.
    function automatic logic [7:0] rd_reg(input logic [6:0] a);
        if (a < 7'(REG_COUNT)) begin
            return regs[a[REG_ADDR_BITS-1:0]];
        end
        return 8'h00;
    endfunction

    assign addr_ok = (addr_q < 7'(REG_COUNT));

    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= 8'h00;
            end
            wr_count <= 8'h00;
            cmd_next <= 1'b1;
            rw_q     <= 1'b0;
            addr_q   <= 7'h00;
            tx_data  <= 8'h00;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;
            if (start) begin
                cmd_next <= 1'b1;
                tx_data  <= wr_count; // Status stays up for the command byte.
            end else if (byte_done && cmd_next) begin
                cmd_next <= 1'b0;
                rw_q     <= rx_byte.cmd.rw;
                addr_q   <= rx_byte.cmd.addr;
                if (rx_byte.cmd.rw) begin
                    tx_data <= rd_reg(rx_byte.cmd.addr);
                end
            end else if (byte_done) begin
                addr_q <= addr_q + 7'd1; // Burst moves to the next address.
                if (rw_q) begin
                    tx_data <= rd_reg(addr_q + 7'd1);
                end else begin
                    wr_valid <= 1'b1; // Reported even when dropped.
                    if (addr_ok) begin
                        regs[addr_q[REG_ADDR_BITS-1:0]] <= rx_byte.data;
                        wr_count <= wr_count + 8'd1;
                    end
                end
            end
        end
    end

    // Event payload, qualified by wr_valid.
    always_ff @(posedge clk_raw) begin
        if (byte_done && !cmd_next && !rw_q) begin
            ev_addr <= addr_q;
            ev_data <= rx_byte.data;
        end
    end

    assign wr_event = '{valid: wr_valid, addr: ev_addr, data: ev_data};

    // The shift engine loads on the start strobe itself, so status bypasses tx_data.
    assign tx_byte = start ? wr_count : tx_data;

endmodule

`default_nettype wire

// File: spi_slave/spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine (
    input  logic                clk_raw,
    input  logic                rst_n,
    input  spi_pkg::spi_edges_t edges,
    input  logic [7:0]          tx_byte,
    output spi_pkg::spi_frame_u rx_byte,
    output logic                byte_done,
    output logic                miso,
    output logic                miso_en
);
    import spi_pkg::*;

    logic [FRAME_CNT_BITS-1:0] bit_cnt;
    logic [FRAME_BITS-1:0]     rx_sh;
    logic [FRAME_BITS-1:0]     tx_sh;
    logic                      load_pending; // Next shift loads a fresh byte.
    logic                      last_bit;

    assign last_bit = (bit_cnt == FRAME_CNT_BITS'(FRAME_BITS - 1));

    // Bit count, byte boundary and the open-transaction level.
    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt      <= '0;
            load_pending <= 1'b0;
            byte_done    <= 1'b0;
            miso_en      <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (edges.start) begin
                bit_cnt      <= '0;
                load_pending <= 1'b1; // Lets a leading-edge shift re-present the MSB.
                miso_en      <= 1'b1;
            end else if (edges.stop) begin
                miso_en <= 1'b0;
            end else if (edges.sample && miso_en) begin
                bit_cnt      <= bit_cnt + 1'b1; // Wraps for back-to-back bytes.
                load_pending <= last_bit;
                byte_done    <= last_bit;
            end else if (edges.shift && miso_en) begin
                load_pending <= 1'b0;
            end
        end
    end

    // Receive side. The full byte sits here while byte_done is high.
    always_ff @(posedge clk_raw) begin
        if (edges.sample && miso_en) begin
            rx_sh <= {rx_sh[FRAME_BITS-2:0], edges.mosi};
        end
    end

    assign rx_byte = rx_sh;

    // Transmit side.
    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            tx_sh <= '0;
        end else if (edges.stop) begin
            tx_sh <= '0; // Quiet miso between transactions.
        end else if (edges.start) begin
            tx_sh <= tx_byte; // MSB is out before the first edge.
        end else if (edges.shift && miso_en) begin
            if (load_pending) begin
                tx_sh <= tx_byte; // Byte boundary.
            end else begin
                tx_sh <= {tx_sh[FRAME_BITS-2:0], 1'b0};
            end
        end
    end

    assign miso = tx_sh[FRAME_BITS-1];

endmodule

`default_nettype wire

// File: spi_slave/spi_pin_sync.sv
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sync (
    input  logic                clk_raw,
    input  logic                rst_n,
    input  spi_pkg::spi_mode_t  mode,
    input  logic                sclk,
    input  logic                mosi,
    input  logic                csn,
    output spi_pkg::spi_edges_t edges
);
    logic [1:0] sclk_s;
    logic [1:0] mosi_s;
    logic [1:0] csn_s;
    logic       sclk_d; // Previous synchronized sclk.
    logic       csn_d;

    logic       lvl_cur;
    logic       lvl_prev;
    logic       lead;
    logic       trail;
    logic       active;

    // Two-flop synchronizers plus one history stage.
    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            sclk_s <= 2'b00;
            mosi_s <= 2'b00;
            csn_s  <= 2'b11; // Bus idle.
            sclk_d <= 1'b0;
            csn_d  <= 1'b1;
        end else begin
            sclk_s <= {sclk_s[0], sclk};
            mosi_s <= {mosi_s[0], mosi};
            csn_s  <= {csn_s[0], csn};
            sclk_d <= sclk_s[1];
            csn_d  <= csn_s[1];
        end
    end

    // Fold polarity in, so leading is always idle to active.
    assign lvl_cur  = sclk_s[1] ^ mode.cpol;
    assign lvl_prev = sclk_d ^ mode.cpol;
    assign active   = ~csn_s[1];
    assign lead     = active & lvl_cur & ~lvl_prev;
    assign trail    = active & ~lvl_cur & lvl_prev;

    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            edges <= '0;
        end else begin
            edges.start <= csn_d & ~csn_s[1];
            edges.stop  <= ~csn_d & csn_s[1];
            // Phase picks which edge captures and which edge drives.
            if (mode.cpha) begin
                edges.sample <= trail;
                edges.shift  <= lead;
            end else begin
                edges.sample <= lead;
                edges.shift  <= trail;
            end
            edges.mosi <= mosi_s[1]; // Aligned with the sclk path.
        end
    end

endmodule

`default_nettype wire

// File: common/reg_pkg.sv
`default_nettype none

package reg_pkg;

    // Register map size.
    localparam int REG_COUNT = 8;
    localparam int REG_ADDR_BITS = 3; // Index bits of a valid address.

    // Write notification, valid for one clk_raw cycle.
    // Addresses above the map still report, with the full 7-bit address.
    typedef struct packed {
        logic       valid;
        logic [6:0] addr;
        logic [7:0] data;
    } reg_wr_event_t;

endpackage

`default_nettype wire

// File: common/spi_pkg.sv
`default_nettype none

package spi_pkg;

    // Bits per SPI byte, MSB first.
    localparam int FRAME_BITS = 8;
    localparam int FRAME_CNT_BITS = $clog2(FRAME_BITS); // Bit counter width.

    // Clock polarity and phase, held static while csn is low.
    typedef struct packed {
        logic cpol; // Idle level of sclk.
        logic cpha; // 1 shifts on the leading edge.
    } spi_mode_t;

    // One-cycle strobes from the pin synchronizer, in clk_raw.
    typedef struct packed {
        logic start;  // csn fell.
        logic stop;   // csn rose.
        logic sample; // Capture mosi now.
        logic shift;  // Advance miso now.
        logic mosi;   // Synchronized mosi, valid with sample.
    } spi_edges_t;

    // Command byte layout.
    typedef struct packed {
        logic       rw;   // 1 is a read.
        logic [6:0] addr; // Start address of the burst.
    } spi_cmd_t;

    // A received byte seen as a command or as plain data.
    typedef union packed {
        spi_cmd_t         cmd;
        logic [7:0]       data;
    } spi_frame_u;

endpackage

`default_nettype wire
